// ==== gat_coef.f ====
hw/gat_arith_pkg.sv
hw/gat_axil_pkg.sv
hw/gat_stream_fifo.sv
hw/gat_attn_regs.sv
hw/gat_dmvm.sv
hw/gat_coef_top.sv
testbench/coef_checker.sv
testbench/tb_gat_coef.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := tb_gat_coef
FILELIST   := gat_coef.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_gat_coef.sv ====
// testbench for the coefficient engine, loads a over AXI4-Lite and streams a table of Wh rows
module tb_gat_coef;

  localparam int NF              = gat_arith_pkg::NUM_FEATURE_OUT;
  localparam int PERIOD          = 20;
  localparam int NUM_ROWS        = 18;
  localparam int HELD_ROWS       = 3;
  // longest ready gap of the lfsr, plus pipeline and FIFO latency
  localparam int MAX_STALL       = 32;
  localparam int LATENCY         = 10;
  localparam int SETUP_CYCLES    = 200;
  localparam int WATCHDOG_CYCLES = SETUP_CYCLES + NUM_ROWS * (MAX_STALL + LATENCY);

  typedef struct packed {
    logic               src;
    logic [7:0]         node;
    logic signed [11:0] f0;
    logic signed [11:0] df;
    logic [7:0]         exp_value;
  } stim_t;

  // feature k = f0 + k*df, with a_src[k] = k-8 and a_nbr[k] = 5-k
  // so a_src.Wh = -8*f0 + 280*df and a_nbr.Wh = -40*f0 - 640*df
  localparam stim_t STIM [NUM_ROWS] = '{
    '{1'b1, 8'd3, -12'sd20,   12'sd1,   8'd88},
    '{1'b0, 8'd3, 12'sd5,     -12'sd1,  8'd112},
    '{1'b0, 8'd3, 12'sd30,    12'sd2,   8'd0},
    '{1'b0, 8'd3, -12'sd50,   12'sd0,   8'd136},
    '{1'b1, 8'd5, 12'sd100,   -12'sd3,  8'd0},
    '{1'b0, 8'd5, -12'sd100,  -12'sd2,  8'd56},
    '{1'b0, 8'd5, 12'sd0,     -12'sd5,  8'd24},
    '{1'b0, 8'd5, 12'sd7,     12'sd1,   8'd0},
    '{1'b0, 8'd5, -12'sd33,   -12'sd4,  8'd192},
    '{1'b1, 8'd2, -12'sd60,   12'sd4,   8'd160},
    '{1'b0, 8'd2, 12'sd12,    12'sd3,   8'd0},
    '{1'b1, 8'd9, -12'sd200,  12'sd5,   8'd120},
    '{1'b0, 8'd9, 12'sd150,   -12'sd10, 8'd72},
    '{1'b0, 8'd9, -12'sd1000, 12'sd60,  8'd248},
    '{1'b0, 8'd9, 12'sd1000,  -12'sd60, 8'd120},
    '{1'b0, 8'd9, 12'sd2000,  12'sd0,   8'd0},
    '{1'b1, 8'd1, 12'sd0,     12'sd0,   8'd0},
    '{1'b0, 8'd1, -12'sd3,    -12'sd7,  8'd248}
  };

  logic                    clk;
  logic                    rst_n;
  gat_axil_pkg::axil_req_t axil_req;
  gat_axil_pkg::axil_rsp_t axil_rsp;
  logic                    wh_valid;
  gat_arith_pkg::wh_row_t  wh_data;
  logic                    wh_ready;
  logic                    coef_valid;
  gat_arith_pkg::coef_t    coef_data;
  logic                    coef_ready;
  logic [7:0]              exp_value;
  logic                    enabled;
  logic [2*NF-1:0][7:0]    a_tbl;
  logic [31:0]             lfsr;
  int                      errors;
  int                      coefs;
  int                      reads;
  int                      pending;
  int                      tb_errors;

  gat_coef_top #(.NUM_FEATURE_OUT(NF)) gat_coef_top_i (
    .clk(clk), .rst_n(rst_n), .axil_req_i(axil_req), .axil_rsp_o(axil_rsp),
    .wh_valid_i(wh_valid), .wh_data_i(wh_data), .wh_ready_o(wh_ready),
    .coef_valid_o(coef_valid), .coef_data_o(coef_data), .coef_ready_i(coef_ready)
  );

  coef_checker #(.NUM_FEATURE_OUT(NF)) u_checker (
    .clk(clk), .rst_n(rst_n), .enabled_i(enabled), .a_vec_i(a_tbl),
    .wh_valid_i(wh_valid), .wh_ready_i(wh_ready), .wh_data_i(wh_data), .exp_value_i(exp_value),
    .coef_valid_i(coef_valid), .coef_ready_i(coef_ready), .coef_data_i(coef_data),
    .axil_req_i(axil_req), .axil_rsp_i(axil_rsp),
    .errors_o(errors), .coefs_o(coefs), .reads_o(reads), .pending_o(pending)
  );

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [7:0] a_byte(input int i);
    return (i < NF) ? 8'(i - 8) : 8'(5 - (i - NF));
  endfunction

  function automatic gat_arith_pkg::wh_row_t build_row(input stim_t s);
    gat_arith_pkg::wh_row_t r;
    for (int k = 0; k < NF; k++) begin
      r.feat[k] = 12'(int'(s.f0) + k * int'(s.df));
    end
    r.num_node = s.node;
    r.src_flag = s.src;
    return r;
  endfunction

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    @(posedge clk);
    while (!axil_rsp.awready) @(posedge clk);
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(posedge clk);
  endtask

  task automatic axil_read(input logic [7:0] addr);
    @(negedge clk);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    @(posedge clk);
    while (!axil_rsp.arready) @(posedge clk);
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    @(posedge clk);
    while (!axil_rsp.rvalid) @(posedge clk);
  endtask

  task automatic send_row(input int idx);
    @(negedge clk);
    wh_valid  = 1'b1;
    wh_data   = build_row(STIM[idx]);
    exp_value = STIM[idx].exp_value;
    @(posedge clk);
    while (!wh_ready) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // back-pressure, one lfsr bit per cycle
  always @(negedge clk) begin
    coef_ready = lfsr[0];
    lfsr       = lfsr_next(lfsr);
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, %0d of %0d coefficients seen",
             WATCHDOG_CYCLES, coefs, NUM_ROWS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst_n           = 1'b0;
    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    wh_valid        = 1'b0;
    wh_data         = '0;
    exp_value       = '0;
    coef_ready      = 1'b0;
    enabled         = 1'b0;
    lfsr            = 32'hfff735e2;
    tb_errors       = 0;
    for (int i = 0; i < 2 * NF; i++) a_tbl[i] = a_byte(i);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // ============================================================
    // load a, then queue rows with the datapath still disabled
    // ============================================================
    for (int w = 0; w < NF / 2; w++) axil_write(gat_axil_pkg::A_BASE + 8'(4 * w), a_tbl[4*w +: 4]);
    for (int i = 0; i < HELD_ROWS; i++) send_row(i);
    @(negedge clk);
    wh_valid = 1'b0;
    repeat (20) @(negedge clk);
    axil_write(gat_axil_pkg::CTRL_ADDR, 32'h1);
    enabled = 1'b1;

    for (int i = HELD_ROWS; i < NUM_ROWS; i++) send_row(i);
    @(negedge clk);
    wh_valid = 1'b0;
    while (coefs < NUM_ROWS) @(negedge clk);
    repeat (10) @(negedge clk);

    // ============================================================
    // register readback and summary
    // ============================================================
    axil_read(gat_axil_pkg::COUNT_ADDR);
    axil_read(gat_axil_pkg::A_BASE + 8'h14);
    repeat (4) @(negedge clk);
    if (pending != 0) begin
      $display("ERROR: %0d coefficients never left the DUT", pending);
      tb_errors++;
    end
    if (reads != 2) begin
      $display("ERROR: only %0d of 2 register reads were checked", reads);
      tb_errors++;
    end
    $display("rows %0d, coefficients %0d, register reads %0d, errors %0d",
             NUM_ROWS, coefs, reads, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/coef_checker.sv ====
// passive checker, models every coefficient from the attention rule and checks AXI register reads
module coef_checker #(
  parameter int NUM_FEATURE_OUT = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enabled_i,
  input  logic [2*NUM_FEATURE_OUT-1:0][gat_arith_pkg::DATA_WIDTH-1:0] a_vec_i,
  input  logic                    wh_valid_i,
  input  logic                    wh_ready_i,
  input  gat_arith_pkg::wh_row_t  wh_data_i,
  input  logic [7:0]              exp_value_i,
  input  logic                    coef_valid_i,
  input  logic                    coef_ready_i,
  input  gat_arith_pkg::coef_t    coef_data_i,
  input  gat_axil_pkg::axil_req_t axil_req_i,
  input  gat_axil_pkg::axil_rsp_t axil_rsp_i,
  output int                      errors_o,
  output int                      coefs_o,
  output int                      reads_o,
  output int                      pending_o
);

  localparam int A_BYTES = 2 * NUM_FEATURE_OUT;

  gat_arith_pkg::coef_t model_q [$];
  logic [7:0]           table_q [$];
  int                   score;
  logic                 rd_check;
  logic [31:0]          rd_expect;

  // signed dot product of the row with the half of a starting at base
  function automatic int dot(input gat_arith_pkg::wh_row_t row, input int base);
    int acc;
    acc = 0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc = acc + int'($signed(row.feat[k])) * int'($signed(a_vec_i[base + k]));
    end
    return acc;
  endfunction

  function automatic void check_field(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAILED time=%0t signal=%s expected=%0d actual=%0d", $time, name, expected, actual);
      errors_o++;
    end
  endfunction

  always @(posedge clk) begin
    gat_arith_pkg::coef_t m;
    int                   sum;
    if (!rst_n) begin
      model_q.delete();
      table_q.delete();
      score     = 0;
      rd_check  = 1'b0;
      errors_o  = 0;
      coefs_o   = 0;
      reads_o   = 0;
      pending_o = 0;
    end else begin
      // ============================================================
      // register reads
      // ============================================================
      if (axil_req_i.arvalid && axil_rsp_i.arready) begin
        rd_check = 1'b1;
        if (axil_req_i.araddr == gat_axil_pkg::COUNT_ADDR) begin
          rd_expect = 32'(coefs_o);
        end else if (int'(axil_req_i.araddr) < A_BYTES) begin
          rd_expect = a_vec_i[(axil_req_i.araddr & 8'hfc) +: 4];
        end else begin
          rd_check = 1'b0;
        end
      end
      if (axil_rsp_i.rvalid && axil_req_i.rready && rd_check) begin
        if (axil_rsp_i.rdata !== rd_expect) begin
          $display("FAILED time=%0t signal=axil_rsp_o.rdata expected=%h actual=%h",
                   $time, rd_expect, axil_rsp_i.rdata);
          errors_o++;
        end
        reads_o++;
        rd_check = 1'b0;
      end

      // every response is OKAY
      if (axil_rsp_i.bvalid && axil_req_i.bready && axil_rsp_i.bresp !== 2'b00) begin
        $display("FAILED time=%0t signal=axil_rsp_o.bresp expected=0 actual=%0d",
                 $time, axil_rsp_i.bresp);
        errors_o++;
      end
      if (axil_rsp_i.rvalid && axil_req_i.rready && axil_rsp_i.rresp !== 2'b00) begin
        $display("FAILED time=%0t signal=axil_rsp_o.rresp expected=0 actual=%0d",
                 $time, axil_rsp_i.rresp);
        errors_o++;
      end

      // ============================================================
      // coefficient stream
      // ============================================================
      if (coef_valid_i && !enabled_i) begin
        $display("ERROR: time=%0t a coefficient appeared while the datapath was disabled", $time);
        errors_o++;
      end
      if (coef_valid_i && coef_ready_i) begin
        if (model_q.size() == 0) begin
          $display("ERROR: time=%0t a coefficient arrived with no input row left", $time);
          errors_o++;
        end else begin
          m = model_q.pop_front();
          check_field("coef_data_o.value", m.value, coef_data_i.value);
          check_field("coef_data_o.value(table)", table_q.pop_front(), coef_data_i.value);
          check_field("coef_data_o.num_node", m.num_node, coef_data_i.num_node);
          check_field("coef_data_o.src_flag", m.src_flag, coef_data_i.src_flag);
        end
        coefs_o++;
      end

      // a source row replaces the score before its own self pair
      if (wh_valid_i && wh_ready_i) begin
        if (wh_data_i.src_flag) score = dot(wh_data_i, 0);
        sum        = score + dot(wh_data_i, NUM_FEATURE_OUT);
        m.value    = (sum < 0) ? 8'd0 : 8'(sum);
        m.num_node = wh_data_i.num_node;
        m.src_flag = wh_data_i.src_flag;
        model_q.push_back(m);
        table_q.push_back(exp_value_i);
      end
      pending_o = model_q.size();
    end
  end

endmodule

// ==== hw/gat_coef_top.sv ====
// attention coefficient engine top: register slave, Wh FIFO, dot-product pipeline, coef FIFO
module gat_coef_top #(
  parameter int NUM_FEATURE_OUT = gat_arith_pkg::NUM_FEATURE_OUT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  gat_axil_pkg::axil_req_t axil_req_i,
  output gat_axil_pkg::axil_rsp_t axil_rsp_o,
  input  logic                    wh_valid_i,
  input  gat_arith_pkg::wh_row_t  wh_data_i,
  output logic                    wh_ready_o,
  output logic                    coef_valid_o,
  output gat_arith_pkg::coef_t    coef_data_o,
  input  logic                    coef_ready_i
);

  localparam int IN_DEPTH   = 4;
  localparam int OUT_DEPTH  = 16;
  localparam int NUM_STAGES = $clog2(NUM_FEATURE_OUT) + 1;
  localparam int LATENCY    = NUM_STAGES + 2;
  localparam int CNT_W      = $clog2(OUT_DEPTH + 1);

  logic [2*NUM_FEATURE_OUT-1:0][gat_arith_pkg::DATA_WIDTH-1:0] a_vec;
  logic                   enable;
  logic                   coef_fire;
  logic                   row_valid;
  gat_arith_pkg::wh_row_t row;
  logic                   pop;
  logic                   dmvm_valid;
  gat_arith_pkg::coef_t   dmvm_coef;
  logic                   out_wr_ready;
  logic [CNT_W-1:0]       out_free;
  logic [CNT_W-1:0]       in_flight;

  // struct widths come from the package, so the two counts must agree
  if (NUM_FEATURE_OUT != gat_arith_pkg::NUM_FEATURE_OUT) begin : g_feat_check
    $error("NUM_FEATURE_OUT differs from gat_arith_pkg");
  end
  if (OUT_DEPTH <= LATENCY) begin : g_depth_check
    $error("output FIFO shallower than the pipeline");
  end

  gat_attn_regs #(
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .a_vec_o     (a_vec),
    .enable_o    (enable),
    .coef_fire_i (coef_fire)
  );

  gat_stream_fifo #(
    .DEPTH     (IN_DEPTH),
    .payload_t (gat_arith_pkg::wh_row_t)
  ) u_in_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (wh_valid_i),
    .wr_data_i  (wh_data_i),
    .wr_ready_o (wh_ready_o),
    .rd_valid_o (row_valid),
    .rd_data_o  (row),
    .rd_ready_i (pop),
    .free_o     ()
  );

  // ============================================================
  // credit rule
  // ============================================================
  // a row enters only if a slot is waiting for it downstream
  assign pop = enable && row_valid && (out_free > in_flight);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + CNT_W'(pop) - CNT_W'(dmvm_valid);
    end
  end

  gat_dmvm #(
    .NUM_FEATURE_OUT(NUM_FEATURE_OUT)
  ) u_dmvm (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (pop),
    .row_i       (row),
    .a_vec_i     (a_vec),
    .out_valid_o (dmvm_valid),
    .coef_o      (dmvm_coef)
  );

  gat_stream_fifo #(
    .DEPTH     (OUT_DEPTH),
    .payload_t (gat_arith_pkg::coef_t)
  ) u_out_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (dmvm_valid),
    .wr_data_i  (dmvm_coef),
    .wr_ready_o (out_wr_ready),
    .rd_valid_o (coef_valid_o),
    .rd_data_o  (coef_data_o),
    .rd_ready_i (coef_ready_i),
    .free_o     (out_free)
  );

  assign coef_fire = coef_valid_o && coef_ready_i;

  // the pipeline has no stall, so credits must always leave room
  a_credit_room: assert property (@(posedge clk) disable iff (!rst_n)
    dmvm_valid |-> out_wr_ready)
    else $error("coefficient arrived at a full output FIFO");

endmodule

// ==== hw/gat_dmvm.sv ====
// pipelined dual dot product a_src.Wh and a_nbr.Wh with source-score latch and ReLU
module gat_dmvm #(
  parameter int NUM_FEATURE_OUT = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid_i,
  input  gat_arith_pkg::wh_row_t row_i,
  input  logic [2*NUM_FEATURE_OUT-1:0][gat_arith_pkg::DATA_WIDTH-1:0] a_vec_i,
  output logic                   out_valid_o,
  output gat_arith_pkg::coef_t   coef_o
);

  localparam int DW         = gat_arith_pkg::DMVM_DATA_WIDTH;
  localparam int NW         = gat_arith_pkg::NUM_NODE_WIDTH;
  // multiply stage plus the adder tree levels
  localparam int NUM_STAGES = $clog2(NUM_FEATURE_OUT) + 1;
  localparam int LAST       = NUM_STAGES - 1;

  logic signed [DW-1:0]          src_t [NUM_STAGES][NUM_FEATURE_OUT];
  logic signed [DW-1:0]          nbr_t [NUM_STAGES][NUM_FEATURE_OUT];
  logic [NUM_STAGES-1:0]         vld_q;
  logic [NUM_STAGES-1:0]         flag_q;
  logic [NUM_STAGES-1:0][NW-1:0] node_q;
  logic signed [DW-1:0]          score_q;
  logic signed [DW-1:0]          score_d;
  logic signed [DW:0]            sum_q;
  logic                          sum_vld_q;
  logic                          sum_flag_q;
  logic [NW-1:0]                 sum_node_q;
  logic                          out_vld_q;
  gat_arith_pkg::coef_t          coef_q;

  // operands left at tree level l, floor halving, never below one
  function automatic int lvl_size(input int l);
    int s;
    s = NUM_FEATURE_OUT;
    for (int j = 0; j < l; j++) begin
      s = (s > 1) ? s / 2 : 1;
    end
    return s;
  endfunction

  // ============================================================
  // stage 0, products
  // ============================================================
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      src_t[0][k] <= $signed(row_i.feat[k]) * $signed(a_vec_i[k]);
      nbr_t[0][k] <= $signed(row_i.feat[k]) * $signed(a_vec_i[NUM_FEATURE_OUT + k]);
    end
  end

  // ============================================================
  // adder tree, both vectors side by side
  // ============================================================
  for (genvar l = 1; l < NUM_STAGES; l++) begin : g_level
    localparam int IN_N  = lvl_size(l - 1);
    localparam int OUT_N = lvl_size(l);
    for (genvar k = 0; k < OUT_N; k++) begin : g_node
      if (IN_N == 1) begin : g_pass
        // tree already reduced, just keep the timing
        always_ff @(posedge clk) begin
          src_t[l][k] <= src_t[l-1][k];
          nbr_t[l][k] <= nbr_t[l-1][k];
        end
      end else if ((IN_N % 2 == 1) && (k == OUT_N - 1)) begin : g_add3
        // odd count, last node absorbs the leftover operand
        always_ff @(posedge clk) begin
          src_t[l][k] <= src_t[l-1][2*k] + src_t[l-1][2*k+1] + src_t[l-1][2*k+2];
          nbr_t[l][k] <= nbr_t[l-1][2*k] + nbr_t[l-1][2*k+1] + nbr_t[l-1][2*k+2];
        end
      end else begin : g_add2
        always_ff @(posedge clk) begin
          src_t[l][k] <= src_t[l-1][2*k] + src_t[l-1][2*k+1];
          nbr_t[l][k] <= nbr_t[l-1][2*k] + nbr_t[l-1][2*k+1];
        end
      end
    end
  end

  // ============================================================
  // source latch, sum and ReLU
  // ============================================================
  // a source row pairs with its own score
  assign score_d = (vld_q[LAST] && flag_q[LAST]) ? src_t[LAST][0] : score_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q     <= '0;
      sum_vld_q <= 1'b0;
      out_vld_q <= 1'b0;
      score_q   <= '0;
    end else begin
      vld_q     <= {vld_q[NUM_STAGES-2:0], in_valid_i};
      sum_vld_q <= vld_q[LAST];
      out_vld_q <= sum_vld_q;
      score_q   <= score_d;
    end
  end

  always_ff @(posedge clk) begin
    flag_q          <= {flag_q[NUM_STAGES-2:0], row_i.src_flag};
    node_q          <= {node_q[NUM_STAGES-2:0], row_i.num_node};
    sum_q           <= score_d + nbr_t[LAST][0];
    sum_flag_q      <= flag_q[LAST];
    sum_node_q      <= node_q[LAST];
    // negative sums clamp to zero, otherwise keep the low byte
    coef_q.value    <= sum_q[DW] ? '0 : sum_q[gat_arith_pkg::DATA_WIDTH-1:0];
    coef_q.num_node <= sum_node_q;
    coef_q.src_flag <= sum_flag_q;
  end

  assign out_valid_o = out_vld_q;
  assign coef_o      = coef_q;

  a_row_known: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i |-> !$isunknown(row_i))
    else $error("unknown bits on an accepted Wh row");

endmodule

// ==== hw/gat_attn_regs.sv ====
// AXI4-Lite slave holding the attention vector a, the enable bit and the coefficient count
module gat_attn_regs #(
  parameter int NUM_FEATURE_OUT = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  gat_axil_pkg::axil_req_t axil_req_i,
  output gat_axil_pkg::axil_rsp_t axil_rsp_o,
  output logic [2*NUM_FEATURE_OUT-1:0][gat_arith_pkg::DATA_WIDTH-1:0] a_vec_o,
  output logic                    enable_o,
  input  logic                    coef_fire_i
);

  localparam int A_BYTES = 2 * NUM_FEATURE_OUT;
  localparam int A_WORDS = (A_BYTES + 3) / 4;
  localparam int AW      = gat_axil_pkg::AXIL_ADDR_W;
  localparam int DW      = gat_axil_pkg::AXIL_DATA_W;

  logic [A_BYTES-1:0][gat_arith_pkg::DATA_WIDTH-1:0] a_q;
  logic          enable_q;
  logic          bvalid_q;
  logic          rvalid_q;
  logic [DW-1:0] count_q;
  logic [DW-1:0] rdata_q;
  logic [DW-1:0] rd_word;
  logic          wr_fire;
  logic          rd_fire;
  logic [AW-1:0] aw_off;
  logic [AW-1:0] ar_off;
  logic          aw_in_a;
  logic          ar_in_a;

  // ============================================================
  // handshakes
  // ============================================================
  // address and data are taken in the same cycle, one write outstanding
  assign wr_fire = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_fire = axil_req_i.arvalid && !rvalid_q;

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = wr_fire;
    axil_rsp_o.wready  = wr_fire;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = !rvalid_q;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
  end

  // ============================================================
  // address decode
  // ============================================================
  assign aw_off  = axil_req_i.awaddr - gat_axil_pkg::A_BASE;
  assign ar_off  = axil_req_i.araddr - gat_axil_pkg::A_BASE;
  assign aw_in_a = (axil_req_i.awaddr >= gat_axil_pkg::A_BASE) && (aw_off < AW'(4 * A_WORDS));
  assign ar_in_a = (axil_req_i.araddr >= gat_axil_pkg::A_BASE) && (ar_off < AW'(4 * A_WORDS));

  // a vector, one byte lane per strobe bit
  always_ff @(posedge clk) begin
    if (wr_fire && aw_in_a) begin
      for (int i = 0; i < A_BYTES; i++) begin
        if (aw_off[AW-1:2] == i / 4 && axil_req_i.wstrb[i % 4]) begin
          a_q[i] <= axil_req_i.wdata[8*(i%4) +: 8];
        end
      end
    end
  end

  always_comb begin
    rd_word = '0;
    if (axil_req_i.araddr == gat_axil_pkg::CTRL_ADDR) begin
      rd_word[0] = enable_q;
    end else if (axil_req_i.araddr == gat_axil_pkg::COUNT_ADDR) begin
      rd_word = count_q;
    end else if (ar_in_a) begin
      for (int i = 0; i < A_BYTES; i++) begin
        if (ar_off[AW-1:2] == i / 4) rd_word[8*(i%4) +: 8] = a_q[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= rd_word;
  end

  // ============================================================
  // control state
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (wr_fire && axil_req_i.awaddr == gat_axil_pkg::CTRL_ADDR && axil_req_i.wstrb[0]) begin
        enable_q <= axil_req_i.wdata[0];
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
      // coefficients taken by the consumer
      if (coef_fire_i) count_q <= count_q + 1'b1;
    end
  end

  assign a_vec_o  = a_q;
  assign enable_o = enable_q;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_q && !axil_req_i.bready |=> bvalid_q)
    else $error("bvalid dropped before bready");

endmodule

// ==== hw/gat_stream_fifo.sv ====
// synchronous valid/ready FIFO, payload type chosen per instance, free-slot count for credits
module gat_stream_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0],
  localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CNT_W     = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_valid_i,
  input  payload_t         wr_data_i,
  output logic             wr_ready_o,
  output logic             rd_valid_o,
  output payload_t         rd_data_o,
  input  logic             rd_ready_i,
  output logic [CNT_W-1:0] free_o
);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             wr_ready_q;
  logic             wr_fire;
  logic             rd_fire;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_fire    = wr_valid_i && wr_ready_q;
  assign rd_fire    = rd_valid_o && rd_ready_i;
  assign wr_ready_o = wr_ready_q;
  assign rd_valid_o = (count != '0);
  assign rd_data_o  = mem[rd_ptr];
  assign free_o     = CNT_W'(DEPTH) - count;
  assign count_nxt  = count + CNT_W'(wr_fire) - CNT_W'(rd_fire);

  // ready is registered, so it stays low for the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      wr_ready_q <= 1'b0;
    end else begin
      if (wr_fire) wr_ptr <= next_ptr(wr_ptr);
      if (rd_fire) rd_ptr <= next_ptr(rd_ptr);
      count      <= count_nxt;
      wr_ready_q <= (count_nxt != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) mem[wr_ptr] <= wr_data_i;
  end

  // occupancy bookkeeping must agree with the handshakes
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_fire |-> (count < CNT_W'(DEPTH)))
    else $error("write accepted while full");

  // equal pointers mean empty unless the count says full
  a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_fire |-> (rd_ptr != wr_ptr) || (count == CNT_W'(DEPTH)))
    else $error("read accepted while empty");

endmodule

// ==== hw/gat_axil_pkg.sv ====
// AXI4-Lite channel bundles and register offsets for the attention weight slave
package gat_axil_pkg;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  // ============================================================
  // register map
  // ============================================================
  // a vector, four bytes per word, byte 0 of a in the low lane
  localparam logic [AXIL_ADDR_W-1:0] A_BASE     = 8'h00;
  // bit 0 enables the datapath
  localparam logic [AXIL_ADDR_W-1:0] CTRL_ADDR  = 8'h40;
  // coefficients accepted downstream, read only
  localparam logic [AXIL_ADDR_W-1:0] COUNT_ADDR = 8'h44;

  // master to slave
  typedef struct packed {
    logic                     awvalid;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage

// ==== hw/gat_arith_pkg.sv ====
// numeric formats and row/coefficient structs, referenced by scoped name from the datapath
package gat_arith_pkg;

  // ============================================================
  // number formats
  // ============================================================
  // default feature count, the top level must match it
  localparam int NUM_FEATURE_OUT = 16;
  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 12;
  localparam int DMVM_DATA_WIDTH = 19;
  localparam int NUM_NODE_WIDTH  = 8;

  // ============================================================
  // stream payloads
  // ============================================================
  // one projected row, feature k pairs with a[k] and a[NUM_FEATURE_OUT+k]
  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] feat;
    logic [NUM_NODE_WIDTH-1:0]                     num_node;
    logic                                          src_flag;
  } wh_row_t;

  // one unnormalized coefficient with its row tags
  typedef struct packed {
    logic [DATA_WIDTH-1:0]     value;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } coef_t;

endpackage
